// File: rtl/conv_mdc_pkg.sv
/* shared types and constants of the convolution engine.
   every block refers to them by scoped name. */
`default_nettype none

package conv_mdc_pkg;

  // sizes --------------------
  localparam int unsigned N_CORES        = 2;                     // cores receiving the event.
  localparam int unsigned ID_WIDTH       = 10;                    // peripheral transaction id.
  localparam int unsigned FIFO_DEPTH     = 4;                     // sample buffer entries.
  localparam int unsigned FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  // register byte offsets --------------------
  localparam logic [7:0] REG_START  = 8'h00; // any write starts a job.
  localparam logic [7:0] REG_STATUS = 8'h04; // bit 0 is busy.
  localparam logic [7:0] REG_SRC    = 8'h08;
  localparam logic [7:0] REG_DST    = 8'h0C;
  localparam logic [7:0] REG_LEN    = 8'h10;
  localparam logic [7:0] REG_COEFF  = 8'h14; // c2, c1, c0 from bit 23 down.

  typedef logic [31:0]                addr_t;   // byte address.
  typedef logic [31:0]                word_t;   // data word.
  typedef logic [15:0]                len_t;    // word count.
  typedef logic signed [7:0]          coeff_t;  // filter tap.
  typedef logic [ID_WIDTH-1:0]        periph_id_t;
  typedef logic [FIFO_PTR_WIDTH-1:0]  fifo_ptr_t;
  typedef logic [FIFO_CNT_WIDTH-1:0]  fifo_cnt_t;

  // bus structs --------------------
  typedef struct packed {
    logic        req;
    addr_t       add;
    logic        wen;   // high for read.
    logic [3:0]  be;
    word_t       data;
  } tcdm_req_t;

  typedef struct packed {
    logic        gnt;
    word_t       r_data;
    logic        r_valid;
  } tcdm_rsp_t;

  typedef struct packed {
    logic        req;
    addr_t       add;
    logic        wen;
    logic [3:0]  be;
    word_t       data;
    periph_id_t  id;
  } periph_req_t;

  typedef struct packed {
    logic        gnt;
    word_t       r_data;
    logic        r_valid;
    periph_id_t  r_id;
  } periph_rsp_t;

  // job configuration, regfile to loader and engine.
  typedef struct packed {
    addr_t       src;
    addr_t       dst;
    len_t        len;
    coeff_t      c0;
    coeff_t      c1;
    coeff_t      c2;
  } job_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    STORE
  } engine_state_e;

endpackage

`default_nettype wire

// File: rtl/conv_mdc_regfile.sv
/* peripheral register file: job configuration, start pulse and busy status.
   accesses are granted at once and answered one cycle later. */
`default_nettype none

module conv_mdc_regfile (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  conv_mdc_pkg::periph_req_t periph_req_i,
  output conv_mdc_pkg::periph_rsp_t periph_rsp_o,
  input  logic                      done_i,
  output conv_mdc_pkg::job_cfg_t    cfg_o,
  output logic                      start_o
);

  conv_mdc_pkg::job_cfg_t   cfg_q;
  logic                     busy_q;
  logic                     start_q;
  logic                     wr_en;
  logic                     rd_en;
  logic [7:0]               offset;
  logic                     busy;
  conv_mdc_pkg::word_t      rdata;
  logic                     r_valid_q;
  conv_mdc_pkg::word_t      r_data_q;
  conv_mdc_pkg::periph_id_t r_id_q;

  assign offset = periph_req_i.add[7:0];                 // low byte selects the register.
  assign wr_en  = periph_req_i.req & ~periph_req_i.wen;
  assign rd_en  = periph_req_i.req &  periph_req_i.wen;
  assign busy   = busy_q & ~done_i;                      // drops with the done pulse.

  // read mux --------------------
  always_comb begin
    rdata = '0;
    case (offset)
      conv_mdc_pkg::REG_STATUS: rdata = {31'b0, busy};
      conv_mdc_pkg::REG_SRC:    rdata = cfg_q.src;
      conv_mdc_pkg::REG_DST:    rdata = cfg_q.dst;
      conv_mdc_pkg::REG_LEN:    rdata = {16'b0, cfg_q.len};
      conv_mdc_pkg::REG_COEFF:  rdata = {8'b0, cfg_q.c2, cfg_q.c1, cfg_q.c0};
      default:                  rdata = '0;               // start reads as zero.
    endcase
  end

  // job registers --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q   <= '0;
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;                                   // single cycle pulse.
      if (done_i) begin
        busy_q <= 1'b0;
      end
      if (wr_en) begin
        case (offset)
          conv_mdc_pkg::REG_START: begin
            if (!busy_q) begin                           // a running job is not restarted.
              start_q <= 1'b1;
              busy_q  <= 1'b1;
            end
          end
          conv_mdc_pkg::REG_SRC: cfg_q.src <= periph_req_i.data;
          conv_mdc_pkg::REG_DST: cfg_q.dst <= periph_req_i.data;
          conv_mdc_pkg::REG_LEN: cfg_q.len <= periph_req_i.data[15:0];
          conv_mdc_pkg::REG_COEFF: begin
            cfg_q.c0 <= periph_req_i.data[7:0];
            cfg_q.c1 <= periph_req_i.data[15:8];
            cfg_q.c2 <= periph_req_i.data[23:16];
          end
          default: ;                                     // status is read only.
        endcase
      end
    end
  end

  // response, one cycle after the grant.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= periph_req_i.req;                     // writes answer too.
    end
  end

  always_ff @(posedge clk_i) begin
    if (periph_req_i.req) begin
      r_data_q <= rd_en ? rdata : '0;                    // zero data on writes.
      r_id_q   <= periph_req_i.id;
    end
  end

  assign periph_rsp_o.gnt     = periph_req_i.req;        // never stalls.
  assign periph_rsp_o.r_data  = r_data_q;
  assign periph_rsp_o.r_valid = r_valid_q;
  assign periph_rsp_o.r_id    = r_id_q;

  assign cfg_o   = cfg_q;
  assign start_o = start_q;

endmodule

`default_nettype wire

// File: rtl/conv_mdc_loader.sv
/* source loader on tcdm port 0. issues reads while buffer credit remains
   and pushes the returned words into the sample fifo. */
`default_nettype none

module conv_mdc_loader (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  conv_mdc_pkg::job_cfg_t  cfg_i,
  output conv_mdc_pkg::tcdm_req_t tcdm_req_o,
  input  conv_mdc_pkg::tcdm_rsp_t tcdm_rsp_i,
  output logic                    push_o,
  output conv_mdc_pkg::word_t     push_data_o,
  input  logic                    pop_i
);

  conv_mdc_pkg::addr_t     addr_q;   // next read address.
  conv_mdc_pkg::len_t      left_q;   // reads still to issue.
  conv_mdc_pkg::fifo_cnt_t credit_q; // reads in flight plus fifo entries.
  logic                    req;
  logic                    grant;

  // request only while a fifo slot is guaranteed for the answer.
  assign req   = (left_q != '0) &&
                 (credit_q < conv_mdc_pkg::fifo_cnt_t'(conv_mdc_pkg::FIFO_DEPTH));
  assign grant = req & tcdm_rsp_i.gnt;

  // issue counter --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      left_q <= '0;
    end else if (start_i) begin
      left_q <= cfg_i.len;
    end else if (grant) begin
      left_q <= left_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= cfg_i.src;
    end else if (grant) begin
      addr_q <= addr_q + 32'd4;                          // word step.
    end
  end

  // credit, up on grant and down on pop.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= '0;
    end else begin
      case ({grant, pop_i})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;                   // both or neither.
      endcase
    end
  end

  // read port, held stable while req is high and not granted.
  always_comb begin
    tcdm_req_o      = '0;
    tcdm_req_o.req  = req;
    tcdm_req_o.add  = addr_q;
    tcdm_req_o.wen  = 1'b1;                              // reads only.
    tcdm_req_o.be   = 4'hF;
  end

  // answers arrive in order, straight into the fifo.
  assign push_o      = tcdm_rsp_i.r_valid;
  assign push_data_o = tcdm_rsp_i.r_data;

endmodule

`default_nettype wire

// File: rtl/conv_mdc_fifo.sv
/* sample buffer between loader and engine. circular, FIFO_DEPTH deep;
   the head word is valid whenever the fifo is not empty. */
`default_nettype none

module conv_mdc_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  conv_mdc_pkg::word_t push_data_i,
  input  logic                pop_i,
  output conv_mdc_pkg::word_t pop_data_o,
  output logic                empty_o
);

  conv_mdc_pkg::word_t     mem_q [conv_mdc_pkg::FIFO_DEPTH];
  conv_mdc_pkg::fifo_ptr_t wr_ptr_q;
  conv_mdc_pkg::fifo_ptr_t rd_ptr_q;
  conv_mdc_pkg::fifo_cnt_t count_q;  // occupancy.

  localparam conv_mdc_pkg::fifo_ptr_t LastPtr =
    conv_mdc_pkg::fifo_ptr_t'(conv_mdc_pkg::FIFO_DEPTH - 1);

  // pointers and count --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage, no reset on data.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q];   // head word.
  assign empty_o    = (count_q == '0);

endmodule

`default_nettype wire

// File: rtl/conv_mdc_engine.sv
/* convolution engine on tcdm port 1. pops samples, forms the three-tap sum
   and stores one result per sample, then pulses done. */
`default_nettype none

module conv_mdc_engine (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  conv_mdc_pkg::job_cfg_t  cfg_i,
  input  logic                    empty_i,
  output logic                    pop_o,
  input  conv_mdc_pkg::word_t     pop_data_i,
  output conv_mdc_pkg::tcdm_req_t tcdm_req_o,
  input  conv_mdc_pkg::tcdm_rsp_t tcdm_rsp_i,
  output logic                    done_o
);

  conv_mdc_pkg::engine_state_e state_q;
  conv_mdc_pkg::job_cfg_t      job_q;    // configuration latched at start.
  conv_mdc_pkg::word_t         hist1_q;  // x[k-1].
  conv_mdc_pkg::word_t         hist2_q;  // x[k-2].
  conv_mdc_pkg::word_t         result_q;
  conv_mdc_pkg::len_t          idx_q;    // results stored so far.
  logic                        done_q;
  conv_mdc_pkg::word_t         c0_ext;
  conv_mdc_pkg::word_t         c1_ext;
  conv_mdc_pkg::word_t         c2_ext;
  conv_mdc_pkg::word_t         sum;
  logic                        store_gnt;
  logic                        last;

  // sign extended taps.
  assign c0_ext = {{24{job_q.c0[7]}}, job_q.c0};
  assign c1_ext = {{24{job_q.c1[7]}}, job_q.c1};
  assign c2_ext = {{24{job_q.c2[7]}}, job_q.c2};

  // three-tap sum, wraps at 32 bits --------------------
  assign sum = c0_ext * pop_data_i + c1_ext * hist1_q + c2_ext * hist2_q;

  assign pop_o     = (state_q == conv_mdc_pkg::RUN) && !empty_i;
  assign store_gnt = (state_q == conv_mdc_pkg::STORE) && tcdm_rsp_i.gnt;
  assign last      = (idx_q == conv_mdc_pkg::len_t'(job_q.len - 1'b1));

  // control --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= conv_mdc_pkg::IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        conv_mdc_pkg::IDLE: begin
          if (start_i) begin
            if (cfg_i.len == '0) begin
              done_q <= 1'b1;                            // empty job ends at once.
            end else begin
              state_q <= conv_mdc_pkg::RUN;
            end
          end
        end
        conv_mdc_pkg::RUN: begin
          if (pop_o) state_q <= conv_mdc_pkg::STORE;
        end
        conv_mdc_pkg::STORE: begin
          if (store_gnt) begin
            if (last) begin
              done_q  <= 1'b1;
              state_q <= conv_mdc_pkg::IDLE;
            end else begin
              state_q <= conv_mdc_pkg::RUN;
            end
          end
        end
        default: state_q <= conv_mdc_pkg::IDLE;
      endcase
    end
  end

  // datapath, cleared by start rather than reset.
  always_ff @(posedge clk_i) begin
    if (start_i && state_q == conv_mdc_pkg::IDLE) begin
      job_q   <= cfg_i;
      hist1_q <= '0;                                     // samples before x[0] are zero.
      hist2_q <= '0;
      idx_q   <= '0;
    end else begin
      if (pop_o) begin
        result_q <= sum;
        hist2_q  <= hist1_q;                             // shift history.
        hist1_q  <= pop_data_i;
      end
      if (store_gnt) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // write port, held until granted.
  always_comb begin
    tcdm_req_o      = '0;
    tcdm_req_o.req  = (state_q == conv_mdc_pkg::STORE);
    tcdm_req_o.add  = job_q.dst + conv_mdc_pkg::addr_t'({idx_q, 2'b00});
    tcdm_req_o.wen  = 1'b0;                              // writes only.
    tcdm_req_o.be   = 4'hF;
    tcdm_req_o.data = result_q;
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// File: rtl/conv_mdc_top_wrap.sv
/* flat-port top level. packs the bus ports into structs and connects
   register file, loader, fifo and engine. */
`default_nettype none

module conv_mdc_top_wrap (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  output logic [conv_mdc_pkg::N_CORES-1:0]      evt_o,
  // tcdm master ports, 0 loads and 1 stores.
  output logic [1:0]                            tcdm_req_o,
  input  logic [1:0]                            tcdm_gnt_i,
  output conv_mdc_pkg::addr_t [1:0]             tcdm_add_o,
  output logic [1:0]                            tcdm_wen_o,
  output logic [1:0][3:0]                       tcdm_be_o,
  output conv_mdc_pkg::word_t [1:0]             tcdm_data_o,
  input  conv_mdc_pkg::word_t [1:0]             tcdm_r_data_i,
  input  logic [1:0]                            tcdm_r_valid_i,
  // peripheral slave port.
  input  logic                                  periph_req_i,
  output logic                                  periph_gnt_o,
  input  conv_mdc_pkg::addr_t                   periph_add_i,
  input  logic                                  periph_wen_i,
  input  logic [3:0]                            periph_be_i,
  input  conv_mdc_pkg::word_t                   periph_data_i,
  input  conv_mdc_pkg::periph_id_t              periph_id_i,
  output conv_mdc_pkg::word_t                   periph_r_data_o,
  output logic                                  periph_r_valid_o,
  output conv_mdc_pkg::periph_id_t              periph_r_id_o
);

  conv_mdc_pkg::periph_req_t periph_req;
  conv_mdc_pkg::periph_rsp_t periph_rsp;
  conv_mdc_pkg::tcdm_req_t   tcdm_req [2];
  conv_mdc_pkg::tcdm_rsp_t   tcdm_rsp [2];
  conv_mdc_pkg::job_cfg_t    cfg;
  conv_mdc_pkg::word_t       push_data;
  conv_mdc_pkg::word_t       pop_data;
  logic                      start;
  logic                      done;
  logic                      push;
  logic                      pop;
  logic                      empty;

  // port packing --------------------
  for (genvar ii = 0; ii < 2; ii++) begin : gen_tcdm
    assign tcdm_req_o[ii]      = tcdm_req[ii].req;
    assign tcdm_add_o[ii]      = tcdm_req[ii].add;
    assign tcdm_wen_o[ii]      = tcdm_req[ii].wen;
    assign tcdm_be_o[ii]       = tcdm_req[ii].be;
    assign tcdm_data_o[ii]     = tcdm_req[ii].data;
    assign tcdm_rsp[ii].gnt     = tcdm_gnt_i[ii];
    assign tcdm_rsp[ii].r_data  = tcdm_r_data_i[ii];
    assign tcdm_rsp[ii].r_valid = tcdm_r_valid_i[ii];
  end

  assign periph_req = '{req: periph_req_i, add: periph_add_i, wen: periph_wen_i,
                        be: periph_be_i, data: periph_data_i, id: periph_id_i};
  assign periph_gnt_o     = periph_rsp.gnt;
  assign periph_r_data_o  = periph_rsp.r_data;
  assign periph_r_valid_o = periph_rsp.r_valid;
  assign periph_r_id_o    = periph_rsp.r_id;

  // blocks --------------------
  conv_mdc_regfile i_regfile (
    .clk_i, .rst_n_i, .periph_req_i(periph_req), .periph_rsp_o(periph_rsp),
    .done_i(done), .cfg_o(cfg), .start_o(start)
  );

  conv_mdc_loader i_loader (
    .clk_i, .rst_n_i, .start_i(start), .cfg_i(cfg),
    .tcdm_req_o(tcdm_req[0]), .tcdm_rsp_i(tcdm_rsp[0]),
    .push_o(push), .push_data_o(push_data), .pop_i(pop)
  );

  conv_mdc_fifo i_fifo (
    .clk_i, .rst_n_i, .push_i(push), .push_data_i(push_data),
    .pop_i(pop), .pop_data_o(pop_data), .empty_o(empty)
  );

  conv_mdc_engine i_engine (
    .clk_i, .rst_n_i, .start_i(start), .cfg_i(cfg), .empty_i(empty),
    .pop_o(pop), .pop_data_i(pop_data),
    .tcdm_req_o(tcdm_req[1]), .tcdm_rsp_i(tcdm_rsp[1]), .done_o(done)
  );

  assign evt_o = {conv_mdc_pkg::N_CORES{done}};  // same pulse to every core.

endmodule

`default_nettype wire

// File: test/tb_conv_mdc_mem.sv
/* two-port word memory for the testbench. port 0 reads, port 1 writes;
   grants follow gnt_mask_i and read data returns one cycle after the grant. */
`default_nettype none

module tb_conv_mdc_mem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [1:0]                gnt_mask_i,   // per-port grant enable.
  input  logic [1:0]                req_i,
  output logic [1:0]                gnt_o,
  input  conv_mdc_pkg::addr_t [1:0] add_i,
  input  logic [1:0]                wen_i,
  input  logic [1:0][3:0]           be_i,
  input  conv_mdc_pkg::word_t [1:0] data_i,
  output conv_mdc_pkg::word_t [1:0] r_data_o,
  output logic [1:0]                r_valid_o,
  input  logic                      load_en_i,    // preload from the testbench.
  input  logic [7:0]                load_idx_i,
  input  conv_mdc_pkg::word_t       load_data_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORDS = 256;               // 1 KiB, byte address bits 9:2.

  conv_mdc_pkg::word_t mem_q [WORDS];

  // fill pattern, never zero and distinct per word.
  function automatic conv_mdc_pkg::word_t fill_word(input int idx);
    fill_word = {16'hC0DE ^ 16'(idx * 7), 16'h5A5A ^ 16'(idx)};
  endfunction

  assign gnt_o = req_i & gnt_mask_i;        // grant only a pending request.

  // storage and read return --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < WORDS; i++) begin
        mem_q[i] <= fill_word(i);
      end
      r_valid_o <= '0;
    end else begin
      r_valid_o <= gnt_o & wen_i;           // reads answer next cycle.
      for (int p = 0; p < 2; p++) begin
        if (gnt_o[p] && wen_i[p]) begin
          r_data_o[p] <= mem_q[add_i[p][9:2]];
        end
        if (gnt_o[p] && !wen_i[p]) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[p][b]) begin
              mem_q[add_i[p][9:2]][8*b +: 8] <= data_i[p][8*b +: 8]; // byte lane.
            end
          end
        end
      end
      if (load_en_i) begin
        mem_q[load_idx_i] <= load_data_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_conv_mdc.sv
/* testbench for the convolution engine. configures jobs over the peripheral
   port, runs them against a two-port memory and checks with a reference model. */
`default_nettype none

module tb_conv_mdc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NSAMP     = 8;     // samples per job.
  localparam int TIMEOUT   = 2000;  // cycles allowed per wait.
  localparam int MEM_WORDS = 256;
  localparam int SRC_A     = 16;    // word indices of the job regions.
  localparam int SRC_C     = 40;
  localparam int DST_A     = 64;
  localparam int DST_B     = 96;
  localparam int DST_C     = 128;
  localparam int DST_S     = 160;
  localparam int DST_Z     = 200;

  logic                             clk;
  logic                             rst_n;
  logic [conv_mdc_pkg::N_CORES-1:0] evt;
  logic [1:0]                       tcdm_req;
  logic [1:0]                       tcdm_gnt;
  conv_mdc_pkg::addr_t [1:0]        tcdm_add;
  logic [1:0]                       tcdm_wen;
  logic [1:0][3:0]                  tcdm_be;
  conv_mdc_pkg::word_t [1:0]        tcdm_data;
  conv_mdc_pkg::word_t [1:0]        tcdm_r_data;
  logic [1:0]                       tcdm_r_valid;
  logic                             periph_req;
  logic                             periph_gnt;
  conv_mdc_pkg::addr_t              periph_add;
  logic                             periph_wen;
  logic [3:0]                       periph_be;
  conv_mdc_pkg::word_t              periph_data;
  conv_mdc_pkg::periph_id_t         periph_id;
  conv_mdc_pkg::word_t              periph_r_data;
  logic                             periph_r_valid;
  conv_mdc_pkg::periph_id_t         periph_r_id;
  logic [1:0]                       gnt_mask;
  logic [1:0]                       mask_bits;
  logic                             stall_en;
  logic                             load_en;
  logic [7:0]                       load_idx;
  conv_mdc_pkg::word_t              load_data;
  logic [31:0]                      data_lfsr;    // sample stream.
  logic [31:0]                      stall_lfsr;   // grant stall stream.
  conv_mdc_pkg::periph_id_t         req_id;
  int                               checks;
  int                               errors;
  int                               evt_count;
  logic                             evt_partial;  // an event missed a core.
  conv_mdc_pkg::word_t              samples [NSAMP];
  conv_mdc_pkg::word_t              snapshot [MEM_WORDS];
  conv_mdc_pkg::coeff_t             c0;
  conv_mdc_pkg::coeff_t             c1;
  conv_mdc_pkg::coeff_t             c2;

  conv_mdc_top_wrap dut (
    .clk_i(clk), .rst_n_i(rst_n), .evt_o(evt),
    .tcdm_req_o(tcdm_req), .tcdm_gnt_i(tcdm_gnt), .tcdm_add_o(tcdm_add),
    .tcdm_wen_o(tcdm_wen), .tcdm_be_o(tcdm_be), .tcdm_data_o(tcdm_data),
    .tcdm_r_data_i(tcdm_r_data), .tcdm_r_valid_i(tcdm_r_valid),
    .periph_req_i(periph_req), .periph_gnt_o(periph_gnt), .periph_add_i(periph_add),
    .periph_wen_i(periph_wen), .periph_be_i(periph_be), .periph_data_i(periph_data),
    .periph_id_i(periph_id), .periph_r_data_o(periph_r_data),
    .periph_r_valid_o(periph_r_valid), .periph_r_id_o(periph_r_id)
  );

  tb_conv_mdc_mem i_mem (
    .clk_i(clk), .rst_n_i(rst_n), .gnt_mask_i(gnt_mask),
    .req_i(tcdm_req), .gnt_o(tcdm_gnt), .add_i(tcdm_add), .wen_i(tcdm_wen),
    .be_i(tcdm_be), .data_i(tcdm_data), .r_data_o(tcdm_r_data), .r_valid_o(tcdm_r_valid),
    .load_en_i(load_en), .load_idx_i(load_idx), .load_data_i(load_data)
  );

  always #50 clk = ~clk;  // 100 ns period.

  // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // reference model --------------------
  // y[k] = c0 x[k] + c1 x[k-1] + c2 x[k-2] with zero history and 32-bit wrap.
  function automatic conv_mdc_pkg::word_t conv_ref(
    input conv_mdc_pkg::word_t  x [NSAMP],
    input int                   k,
    input conv_mdc_pkg::coeff_t a0,
    input conv_mdc_pkg::coeff_t a1,
    input conv_mdc_pkg::coeff_t a2
  );
    int xm1;
    int xm2;
    int acc;
    xm1 = (k >= 1) ? int'(x[k-1]) : 0;
    xm2 = (k >= 2) ? int'(x[k-2]) : 0;
    acc = int'(a0) * int'(x[k]) + int'(a1) * xm1 + int'(a2) * xm2;  // int wraps.
    return conv_mdc_pkg::word_t'(acc);
  endfunction

  // compare tasks --------------------
  task automatic check_word(input string what, input conv_mdc_pkg::word_t got,
                            input conv_mdc_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_id(input string what, input conv_mdc_pkg::periph_id_t got,
                          input conv_mdc_pkg::periph_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Checks failed");
    $finish;
  endtask

  // one peripheral access that also checks the echoed id.
  task automatic periph_access(input logic wen, input logic [7:0] off,
                               input conv_mdc_pkg::word_t wdata,
                               output conv_mdc_pkg::word_t rdata);
    int n;
    @(posedge clk);
    req_id      <= req_id + 1'b1;
    periph_req  <= 1'b1;
    periph_add  <= conv_mdc_pkg::addr_t'(off);
    periph_wen  <= wen;
    periph_be   <= 4'hF;
    periph_data <= wdata;
    periph_id   <= req_id;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!periph_gnt && n < TIMEOUT);
    if (!periph_gnt) fail_timeout("periph grant");
    @(posedge clk);
    periph_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!periph_r_valid && n < TIMEOUT);
    if (!periph_r_valid) fail_timeout("periph r_valid");
    check_id("periph_r_id_o", periph_r_id, periph_id);
    rdata = periph_r_data;
  endtask

  task automatic reg_write(input logic [7:0] off, input conv_mdc_pkg::word_t data);
    conv_mdc_pkg::word_t rsp;
    periph_access(1'b0, off, data, rsp);
    check_word("periph_r_data_o", rsp, '0);  // writes answer with zero data.
  endtask

  task automatic reg_read(input logic [7:0] off, output conv_mdc_pkg::word_t data);
    periph_access(1'b1, off, '0, data);
  endtask

  task automatic wait_event(input int seen);
    int n;
    n = 0;
    while (evt_count == seen && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (evt_count == seen) fail_timeout("evt_o");
  endtask

  // samples --------------------
  task automatic rand_word(output conv_mdc_pkg::word_t w);
    for (int b = 0; b < 32; b++) begin
      w[b] = data_lfsr[0];                 // one step per bit.
      data_lfsr = lfsr_next(data_lfsr);
    end
  endtask

  task automatic mem_load(input int idx, input conv_mdc_pkg::word_t data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_idx  <= 8'(idx);
    load_data <= data;
    @(posedge clk);
    load_en   <= 1'b0;
  endtask

  task automatic load_samples(input int src);
    conv_mdc_pkg::word_t w;
    for (int k = 0; k < NSAMP; k++) begin
      rand_word(w);
      samples[k] = w;
      mem_load(src + k, w);
    end
  endtask

  task automatic config_job(input int src, input int dst, input int len);
    reg_write(conv_mdc_pkg::REG_SRC, conv_mdc_pkg::word_t'(src * 4));
    reg_write(conv_mdc_pkg::REG_DST, conv_mdc_pkg::word_t'(dst * 4));
    reg_write(conv_mdc_pkg::REG_LEN, conv_mdc_pkg::word_t'(len));
    reg_write(conv_mdc_pkg::REG_COEFF, {8'h00, c2, c1, c0});
  endtask

  task automatic run_job(input int src, input int dst, input int len);
    int seen;
    config_job(src, dst, len);
    seen = evt_count;
    reg_write(conv_mdc_pkg::REG_START, 32'h1);
    wait_event(seen);
  endtask

  task automatic check_results(input int dst, input int len);
    for (int k = 0; k < len; k++) begin
      check_word($sformatf("dst word %0d", k), i_mem.mem_q[dst + k],
                 conv_ref(samples, k, c0, c1, c2));
    end
  endtask

  task automatic end_test(input int num, input string name, input int err0);
    $display("test %0d %s: %s", num, name, (errors == err0) ? "pass" : "FAIL");
  endtask

  // grant stalls take one lfsr bit per port per cycle.
  initial begin
    gnt_mask   = 2'b11;
    stall_lfsr = 32'd31;
    forever begin
      @(posedge clk);
      if (stall_en) begin
        for (int p = 0; p < 2; p++) begin
          mask_bits[p] = stall_lfsr[0];
          stall_lfsr   = lfsr_next(stall_lfsr);
        end
        gnt_mask <= mask_bits;
      end else begin
        gnt_mask <= 2'b11;
      end
    end
  end

  // event monitor counts pulses and flags any partial one.
  initial begin
    evt_count   = 0;
    evt_partial = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && evt != '0) begin
        evt_count <= evt_count + 1;
        if (evt != '1) evt_partial <= 1'b1;
      end
    end
  end

  // tests --------------------
  initial begin
    int                  err0;
    int                  seen;
    conv_mdc_pkg::word_t rd;
    clk         = 1'b0;
    rst_n       = 1'b0;
    periph_req  = 1'b0;
    periph_add  = '0;
    periph_wen  = 1'b0;
    periph_be   = '0;
    periph_data = '0;
    periph_id   = '0;
    stall_en    = 1'b0;
    load_en     = 1'b0;
    load_idx    = '0;
    load_data   = '0;
    data_lfsr   = 32'd31;
    req_id      = '0;
    checks      = 0;
    errors      = 0;
    c0          = 8'sd3;
    c1          = -8'sd5;
    c2          = 8'sd7;
    repeat (5) @(posedge clk);              // reset for 5 cycles.
    rst_n <= 1'b1;

    err0 = errors;                          // test 1 register readback.
    reg_write(conv_mdc_pkg::REG_SRC, 32'h1234_5678);
    reg_write(conv_mdc_pkg::REG_DST, 32'hCAFE_0010);
    reg_write(conv_mdc_pkg::REG_LEN, 32'hFFFF_00AB);
    reg_write(conv_mdc_pkg::REG_COEFF, 32'hEE81_7F05);
    reg_read(conv_mdc_pkg::REG_SRC, rd);
    check_word("src", rd, 32'h1234_5678);
    reg_read(conv_mdc_pkg::REG_DST, rd);
    check_word("dst", rd, 32'hCAFE_0010);
    reg_read(conv_mdc_pkg::REG_LEN, rd);
    check_word("len", rd, 32'h0000_00AB);   // 16-bit count.
    reg_read(conv_mdc_pkg::REG_COEFF, rd);
    check_word("coeff", rd, 32'h0081_7F05); // taps in bits 23:0.
    end_test(1, "register readback", err0);

    err0 = errors;                          // test 2 busy and event.
    load_samples(SRC_A);
    config_job(SRC_A, DST_S, 4);
    seen = evt_count;
    reg_write(conv_mdc_pkg::REG_START, 32'h1);
    reg_read(conv_mdc_pkg::REG_STATUS, rd);
    check_word("status while running", rd, 32'h1);
    wait_event(seen);
    reg_read(conv_mdc_pkg::REG_STATUS, rd);
    check_word("status after event", rd, 32'h0);
    check_bit("evt_o on every core", evt_partial, 1'b0);
    end_test(2, "status", err0);

    err0 = errors;                          // test 3 with memory always granting.
    run_job(SRC_A, DST_A, NSAMP);
    check_results(DST_A, NSAMP);
    end_test(3, "convolution", err0);

    err0 = errors;                          // test 4 with random stalls on both ports.
    @(posedge clk);
    stall_en <= 1'b1;
    run_job(SRC_A, DST_B, NSAMP);
    check_results(DST_B, NSAMP);
    end_test(4, "convolution with stalls", err0);

    err0 = errors;                          // test 5 back to back in new regions.
    c0 = -8'sd128;
    c1 = 8'sd127;
    c2 = -8'sd1;
    load_samples(SRC_C);
    run_job(SRC_C, DST_C, NSAMP);
    check_results(DST_C, NSAMP);
    @(posedge clk);
    stall_en <= 1'b0;
    end_test(5, "second job", err0);

    err0 = errors;                          // test 6 where an empty job leaves memory alone.
    for (int i = 0; i < MEM_WORDS; i++) begin
      snapshot[i] = i_mem.mem_q[i];
    end
    run_job(SRC_A, DST_Z, 0);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word($sformatf("mem word %0d", i), i_mem.mem_q[i], snapshot[i]);
    end
    end_test(6, "zero length", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/conv_mdc_pkg.sv
rtl/conv_mdc_regfile.sv
rtl/conv_mdc_loader.sv
rtl/conv_mdc_fifo.sv
rtl/conv_mdc_engine.sv
rtl/conv_mdc_top_wrap.sv
test/tb_conv_mdc_mem.sv
test/tb_conv_mdc.sv

// File: run.sh
#!/bin/sh
# builds the convolution engine testbench with verilator and runs it.
# the exit status follows the result line in the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  -f project.f --top-module tb_conv_mdc -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "All checks passed" sim.log; then
  echo "simulation result: PASS"
  exit 0
else
  echo "simulation result: FAIL"
  exit 1
fi
